/* b2r_top.f */
+incdir+.
b2r_pkg.sv
ram_1w1r.sv
block_row_mux.sv
b2r_converter.sv
row_requantizer.sv
b2r_top.sv
tb_b2r_top.sv

/* Bender.yml */
package:
  name: b2r_top

sources:
  - b2r_pkg.sv
  - ram_1w1r.sv
  - block_row_mux.sv
  - b2r_converter.sv
  - row_requantizer.sv
  - b2r_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_b2r_top.sv

/* tb_b2r_model.svh */
/* Reference model for the default geometry, included inside tb_b2r_top.
   Holds one frame of input words and queues the expected requantized rows. */

logic [WORD_W-1:0]        frame_words [IN_ROWS];
logic [COL*OUT_WIDTH-1:0] exp_rows [$];
logic                     exp_last [$];

// Round half up, floor shift, clamp to the signed output range
function automatic logic [OUT_WIDTH-1:0] expect_quant(input logic [WIDTH-1:0] raw);
    int v;
    v = $signed(raw);
    v = (v + (1 << (FRAC_WIDTH - 1))) >>> FRAC_WIDTH;
    if (v > (1 << (OUT_WIDTH - 1)) - 1) begin
        v = (1 << (OUT_WIDTH - 1)) - 1;
    end else if (v < -(1 << (OUT_WIDTH - 1))) begin
        v = -(1 << (OUT_WIDTH - 1));
    end
    return v[OUT_WIDTH-1:0];
endfunction

// Queue every row of the stored frame in output order
task automatic predict_frame();
    int s, c, nv, b;
    int r, h, e, elem;
    logic [COL*OUT_WIDTH-1:0] line;
    for (int row = 0; row < ROW; row++) begin
        // Row s*CHUNKS + c comes from slice s, chunk c
        s  = row / CHUNKS;
        c  = row % CHUNKS;
        nv = c / (CHUNK_SIZE / BLOCK_SIZE);
        b  = c % (CHUNK_SIZE / BLOCK_SIZE);
        for (int col = 0; col < COL; col++) begin
            r    = col / (NUM_CORES_H * BLOCK_SIZE);
            h    = (col % (NUM_CORES_H * BLOCK_SIZE)) / BLOCK_SIZE;
            e    = col % BLOCK_SIZE;
            elem = h * CHUNK_SIZE * NUM_CORES_V + nv * CHUNK_SIZE + b * BLOCK_SIZE + e;
            line[col*OUT_WIDTH +: OUT_WIDTH] =
                expect_quant(frame_words[s * SLICE_ROWS + r][elem*WIDTH +: WIDTH]);
        end
        exp_rows.push_back(line);
        exp_last.push_back(row == ROW - 1);
    end
endtask

/* tb_b2r_top.sv */
/* Testbench for b2r_top at its default geometry with 16-bit elements.
   Random frames come from an LCG and every row is checked against the model. */
`timescale 1ns/100ps

module tb_b2r_top;

    localparam int WIDTH       = 16;
    localparam int FRAC_WIDTH  = 8;
    localparam int OUT_WIDTH   = 8;
    localparam int ROW         = 8;
    localparam int COL         = 8;
    localparam int BLOCK_SIZE  = 2;
    localparam int CHUNK_SIZE  = 4;
    localparam int NUM_CORES_H = 2;
    localparam int NUM_CORES_V = 2;
    localparam int WORD_W      = WIDTH * CHUNK_SIZE * NUM_CORES_H * NUM_CORES_V;
    localparam int SLICE_ROWS  = COL / (BLOCK_SIZE * NUM_CORES_H);
    localparam int IN_ROWS     = (ROW / (BLOCK_SIZE * NUM_CORES_V)) * SLICE_ROWS;
    localparam int CHUNKS      = NUM_CORES_V * CHUNK_SIZE / BLOCK_SIZE;
    localparam int TIMEOUT     = 500;

    logic                     clk;
    logic                     rst_n;
    logic                     en;
    logic                     in_valid;
    logic [WORD_W-1:0]        in_data;
    logic                     row_valid;
    logic                     row_last;
    logic [COL*OUT_WIDTH-1:0] row_data;
    logic                     busy;

    logic [31:0] lcg_state;
    int          err_count;
    int          row_num;
    bit          in_slice;
    string       test_name;

    `include "tb_b2r_model.svh"

    b2r_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .in_valid (in_valid),
        .in_data  (in_data),
        .row_valid(row_valid),
        .row_last (row_last),
        .row_data (row_data),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Plain random, or a mix of both limits, half-LSB ties and small values
    function automatic logic [WIDTH-1:0] make_elem(input bit extremes);
        logic [31:0] r;
        r = next_rand();
        if (!extremes) begin
            return r[31:16];
        end
        case (r[31:30])
            2'd0:    return 16'h7fff - r[19:16];
            2'd1:    return 16'h8000 + r[19:16];
            2'd2:    return {r[29:23], 9'h080};
            default: return {{4{r[27]}}, r[27:16]};
        endcase
    endfunction

    task automatic send_frame(input bit extremes, input bit gaps, input bit stall);
        logic [WORD_W-1:0] word;
        int tries;
        for (int w = 0; w < IN_ROWS; w++) begin
            for (int i = 0; i < WORD_W / WIDTH; i++) begin
                word[i*WIDTH +: WIDTH] = make_elem(extremes);
            end
            frame_words[w] = word;
            if (gaps) begin
                repeat (next_rand() >> 30) begin
                    @(posedge clk);
                    #2 in_valid = 1'b0;
                end
            end
            // Hold the word until a cycle with en high takes it
            tries = 0;
            do begin
                @(posedge clk);
                #2;
                en       = stall ? ((next_rand() >> 30) != 0) : 1'b1;
                in_valid = 1'b1;
                in_data  = word;
                tries++;
            end while (!en && tries < TIMEOUT);
            if (!en) begin
                $display("%s: input word %0d was never accepted", test_name, w);
                err_count++;
            end
        end
        predict_frame();
    endtask

    task automatic drain_frame(input bit stall, input bit junk);
        int cycles;
        cycles = 0;
        while (exp_rows.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            en = stall ? ((next_rand() >> 30) != 0) : 1'b1;
            // Stray strobes stop before the idle cycle after the final row
            in_valid = junk && exp_rows.size() >= 3;
            in_data  = ~in_data;
            cycles++;
        end
        if (exp_rows.size() != 0) begin
            $display("%s: timed out with %0d rows still missing", test_name, exp_rows.size());
            err_count++;
            exp_rows.delete();
            exp_last.delete();
            row_num = 0;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            en       = 1'b1;
            in_valid = 1'b0;
            cycles++;
        end
        if (busy !== 1'b0) begin
            $display("%s: busy did not fall after the frame", test_name);
            err_count++;
        end
    endtask

    // Row monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && !row_valid && row_last !== 1'b0) begin
            $display("** Error %s: row_last without row_valid expected 0 actual %b",
                     test_name, row_last);
            err_count++;
        end
        if (rst_n && row_valid) begin
            if (busy !== 1'b1) begin
                $display("** Error %s: row %0d busy expected 1 actual %b",
                         test_name, row_num, busy);
                err_count++;
            end
            if (exp_rows.size() == 0) begin
                $display("%s: row_valid with no row expected at %0t", test_name, $time);
                err_count++;
            end else begin
                if (row_data !== exp_rows[0]) begin
                    $display("** Error %s: row %0d expected %h actual %h",
                             test_name, row_num, exp_rows[0], row_data);
                    err_count++;
                end
                if (row_last !== exp_last[0]) begin
                    $display("** Error %s: row %0d row_last expected %b actual %b",
                             test_name, row_num, exp_last[0], row_last);
                    err_count++;
                end
                exp_rows.delete(0);
                exp_last.delete(0);
                in_slice = (row_num % CHUNKS) != CHUNKS - 1;
                row_num  = (row_num + 1) % ROW;
            end
        end else if (rst_n && en && in_slice) begin
            $display("%s: gap inside a slice before row %0d", test_name, row_num);
            err_count++;
            in_slice = 1'b0;
        end
    end

    initial begin
        lcg_state = 32'hdeec_951c;
        err_count = 0;
        row_num   = 0;
        in_slice  = 1'b0;
        rst_n     = 1'b0;
        en        = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (10) begin
            @(negedge clk);
            if (row_valid !== 1'b0 || row_last !== 1'b0 || busy !== 1'b0) begin
                $display("** Error %s: valid/last/busy expected 000 actual %b%b%b",
                         test_name, row_valid, row_last, busy);
                err_count++;
            end
        end
        test_name = "reorder";
        send_frame(1'b0, 1'b0, 1'b0);
        drain_frame(1'b0, 1'b0);
        wait_idle();
        test_name = "requant";
        send_frame(1'b1, 1'b0, 1'b0);
        drain_frame(1'b0, 1'b0);
        wait_idle();
        test_name = "framing";
        send_frame(1'b0, 1'b1, 1'b0);
        drain_frame(1'b0, 1'b1);
        wait_idle();
        test_name = "stall";
        send_frame(1'b1, 1'b1, 1'b1);
        drain_frame(1'b1, 1'b0);
        wait_idle();
        test_name = "back_to_back";
        repeat (3) begin
            send_frame(1'b0, 1'b0, 1'b0);
            drain_frame(1'b0, 1'b0);
        end
        wait_idle();
        // Quiet tail so stray rows still get caught
        repeat (20) @(posedge clk);
        $display("Errors: %0d", err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* b2r_top.sv */
/* Output stage of the tiled matrix engine: frame buffer, reorder, then requantize.
   All geometry parameters are set here and must divide evenly. */
`timescale 1ns/100ps

module b2r_top #(
    parameter int WIDTH       = 16,
    parameter int FRAC_WIDTH  = 8,
    parameter int OUT_WIDTH   = 8,
    parameter int ROW         = 8,
    parameter int COL         = 8,
    parameter int BLOCK_SIZE  = 2,
    parameter int CHUNK_SIZE  = 4,
    parameter int NUM_CORES_H = 2,
    parameter int NUM_CORES_V = 2
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                en,
    input  logic                                                in_valid,
    input  logic [WIDTH*CHUNK_SIZE*NUM_CORES_H*NUM_CORES_V-1:0] in_data,
    output logic                                                row_valid,
    output logic                                                row_last,
    output logic [COL*OUT_WIDTH-1:0]                            row_data,
    output logic                                                busy
);

    // Reordered rows at full precision
    logic                 conv_valid;
    logic                 conv_last;
    logic [COL*WIDTH-1:0] conv_data;

    b2r_converter #(
        .WIDTH      (WIDTH),
        .ROW        (ROW),
        .COL        (COL),
        .BLOCK_SIZE (BLOCK_SIZE),
        .CHUNK_SIZE (CHUNK_SIZE),
        .NUM_CORES_H(NUM_CORES_H),
        .NUM_CORES_V(NUM_CORES_V)
    ) u_converter (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .busy      (busy),
        .conv_valid(conv_valid),
        .conv_last (conv_last),
        .conv_data (conv_data)
    );

    row_requantizer #(
        .COL       (COL),
        .WIDTH     (WIDTH),
        .FRAC_WIDTH(FRAC_WIDTH),
        .OUT_WIDTH (OUT_WIDTH)
    ) u_requant (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .conv_valid(conv_valid),
        .conv_last (conv_last),
        .conv_data (conv_data),
        .row_valid (row_valid),
        .row_last  (row_last),
        .row_data  (row_data)
    );

endmodule

/* row_requantizer.sv */
/* One register stage of round, shift and saturate on every element of a row.
   row_valid and row_last are masked while en is low, and rows held then show up again once en returns. */
`timescale 1ns/100ps

module row_requantizer #(
    parameter int COL        = 8,
    parameter int WIDTH      = 16,
    parameter int FRAC_WIDTH = 8,
    parameter int OUT_WIDTH  = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  logic                     conv_valid,
    input  logic                     conv_last,
    input  logic [COL*WIDTH-1:0]     conv_data,
    output logic                     row_valid,
    output logic                     row_last,
    output logic [COL*OUT_WIDTH-1:0] row_data
);

    logic                     valid_q;
    logic                     last_q;
    logic [COL*OUT_WIDTH-1:0] q_row;

    always_comb begin
        longint q;
        for (int i = 0; i < COL; i++) begin
            q = b2r_pkg::requant_elem(longint'($signed(conv_data[i*WIDTH +: WIDTH])),
                                      FRAC_WIDTH, OUT_WIDTH);
            // Saturated value already fits, so keep the low bits
            q_row[i*OUT_WIDTH +: OUT_WIDTH] = q[OUT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (en) begin
            valid_q <= conv_valid;
            last_q  <= conv_last;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            row_data <= q_row;
        end
    end

    // A row counts only in a cycle with en high
    assign row_valid = valid_q && en;
    assign row_last  = last_q && en;

    a_last_has_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        row_last |-> row_valid
    );

endmodule

/* b2r_converter.sv */
/* Frame buffer controller. A frame is exactly the full ROW x COL matrix in block order.
   en low freezes all state. in_valid is dropped outside idle and fill, and rows have no back-pressure. */
`timescale 1ns/100ps

module b2r_converter #(
    parameter int WIDTH       = 16,
    parameter int ROW         = 8,
    parameter int COL         = 8,
    parameter int BLOCK_SIZE  = 2,
    parameter int CHUNK_SIZE  = 4,
    parameter int NUM_CORES_H = 2,
    parameter int NUM_CORES_V = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   en,
    input  logic                                                   in_valid,
    input  logic [WIDTH*CHUNK_SIZE*NUM_CORES_H*NUM_CORES_V-1:0]    in_data,
    output logic                                                   busy,
    output logic                                                   conv_valid,
    output logic                                                   conv_last,
    output logic [COL*WIDTH-1:0]                                   conv_data
);

    localparam int ELEMS      = CHUNK_SIZE * NUM_CORES_H * NUM_CORES_V;
    localparam int WORD_W     = WIDTH * ELEMS;
    localparam int SLICE_ROWS = COL / (BLOCK_SIZE * NUM_CORES_H);
    localparam int IN_ROWS    = (ROW / (BLOCK_SIZE * NUM_CORES_V)) * SLICE_ROWS;
    localparam int CHUNKS     = NUM_CORES_V * CHUNK_SIZE / BLOCK_SIZE;
    localparam int SLICES     = IN_ROWS / SLICE_ROWS;

    localparam int ADDR_W  = b2r_pkg::clog2_safe(IN_ROWS);
    localparam int LOAD_W  = b2r_pkg::clog2_safe(SLICE_ROWS + 1);
    localparam int CHUNK_W = b2r_pkg::clog2_safe(CHUNKS);
    localparam int SLICE_W = b2r_pkg::clog2_safe(SLICES);

    b2r_pkg::conv_state_e state;

    logic [ADDR_W-1:0]  wr_cnt;
    logic [LOAD_W-1:0]  load_cnt;
    logic [SLICE_W-1:0] slice_cnt;
    logic [CHUNK_W-1:0] chunk_idx;
    // Extra emit cycle that lets the last row leave before the state moves on
    logic               emit_tail;

    logic                   accept;
    logic                   last_chunk;
    logic                   last_slice;
    logic                   ram_we;
    logic [ADDR_W-1:0]      ram_waddr;
    logic [ADDR_W-1:0]      ram_raddr;
    logic [WORD_W-1:0]      ram_dout;
    logic [SLICE_ROWS*WORD_W-1:0] slice_buf;
    logic [COL*WIDTH-1:0]   mux_row;

    assign accept = en && in_valid &&
                    (state == b2r_pkg::idle || state == b2r_pkg::fill);

    assign last_chunk = (chunk_idx == CHUNKS - 1);
    assign last_slice = (slice_cnt == SLICES - 1);

    // Words land in arrival order
    assign ram_we    = accept;
    assign ram_waddr = wr_cnt;

    // The final load cycle only catches the last read, so hold the address in range
    assign ram_raddr = ADDR_W'(slice_cnt * SLICE_ROWS +
                               ((load_cnt == SLICE_ROWS) ? SLICE_ROWS - 1 : load_cnt));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= b2r_pkg::idle;
            wr_cnt     <= '0;
            load_cnt   <= '0;
            slice_cnt  <= '0;
            chunk_idx  <= '0;
            emit_tail  <= 1'b0;
            conv_valid <= 1'b0;
            conv_last  <= 1'b0;
            busy       <= 1'b0;
        end else if (en) begin
            case (state)
                b2r_pkg::idle, b2r_pkg::fill: begin
                    if (accept) begin
                        busy <= 1'b1;
                        if (wr_cnt == IN_ROWS - 1) begin
                            wr_cnt <= '0;
                            state  <= b2r_pkg::slice_load;
                        end else begin
                            wr_cnt <= wr_cnt + 1'b1;
                            state  <= b2r_pkg::fill;
                        end
                    end else if (state == b2r_pkg::idle) begin
                        // Held one idle cycle so busy covers the final row
                        busy <= 1'b0;
                    end
                end

                b2r_pkg::slice_load: begin
                    if (load_cnt == SLICE_ROWS) begin
                        load_cnt  <= '0;
                        chunk_idx <= '0;
                        emit_tail <= 1'b0;
                        state     <= b2r_pkg::emit;
                    end else begin
                        load_cnt <= load_cnt + 1'b1;
                    end
                end

                b2r_pkg::emit: begin
                    if (!emit_tail) begin
                        conv_valid <= 1'b1;
                        conv_last  <= last_chunk && last_slice;
                        if (last_chunk) begin
                            emit_tail <= 1'b1;
                        end else begin
                            chunk_idx <= chunk_idx + 1'b1;
                        end
                    end else begin
                        conv_valid <= 1'b0;
                        conv_last  <= 1'b0;
                        emit_tail  <= 1'b0;
                        chunk_idx  <= '0;
                        if (last_slice) begin
                            slice_cnt <= '0;
                            state     <= b2r_pkg::idle;
                        end else begin
                            slice_cnt <= slice_cnt + 1'b1;
                            state     <= b2r_pkg::slice_load;
                        end
                    end
                end

                default: begin
                    state <= b2r_pkg::idle;
                end
            endcase
        end
    end

    // Slice buffer trails the read address by one cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (state == b2r_pkg::slice_load && load_cnt != 0) begin
                slice_buf[(load_cnt - 1)*WORD_W +: WORD_W] <= ram_dout;
            end
            if (state == b2r_pkg::emit && !emit_tail) begin
                conv_data <= mux_row;
            end
        end
    end

    ram_1w1r #(
        .DATA_WIDTH(WORD_W),
        .DEPTH     (IN_ROWS)
    ) u_frame_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (ram_we),
        .write_addr(ram_waddr),
        .read_addr (ram_raddr),
        .din       (in_data),
        .dout      (ram_dout)
    );

    block_row_mux #(
        .WIDTH      (WIDTH),
        .COL        (COL),
        .BLOCK_SIZE (BLOCK_SIZE),
        .CHUNK_SIZE (CHUNK_SIZE),
        .NUM_CORES_H(NUM_CORES_H),
        .NUM_CORES_V(NUM_CORES_V)
    ) u_row_mux (
        .slice_data(slice_buf),
        .chunk_idx (chunk_idx),
        .row_out   (mux_row)
    );

    // Rows come out only in emit even across an en stall
    a_valid_in_emit: assert property (
        @(posedge clk) disable iff (!rst_n)
        conv_valid |-> (state == b2r_pkg::emit)
    );

    a_last_has_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        conv_last |-> conv_valid
    );

endmodule

/* block_row_mux.sv */
/* Block-to-row permutation over one buffered slice. Purely combinational.
   COL must equal slice_rows * NUM_CORES_H * BLOCK_SIZE for the geometry to be consistent. */
`timescale 1ns/100ps

module block_row_mux #(
    parameter int WIDTH       = 16,
    parameter int COL         = 8,
    parameter int BLOCK_SIZE  = 2,
    parameter int CHUNK_SIZE  = 4,
    parameter int NUM_CORES_H = 2,
    parameter int NUM_CORES_V = 2
) (
    input  logic [(COL / (BLOCK_SIZE * NUM_CORES_H)) * WIDTH * CHUNK_SIZE
                  * NUM_CORES_H * NUM_CORES_V - 1:0]          slice_data,
    input  logic [b2r_pkg::clog2_safe(NUM_CORES_V * CHUNK_SIZE / BLOCK_SIZE)-1:0]
                                                              chunk_idx,
    output logic [COL*WIDTH-1:0]                              row_out
);

    // Elements in one input word
    localparam int ELEMS      = CHUNK_SIZE * NUM_CORES_H * NUM_CORES_V;
    // Output columns covered by one input word
    localparam int SPAN       = NUM_CORES_H * BLOCK_SIZE;

    always_comb begin
        int word;
        int src;
        int pos;
        for (int col = 0; col < COL; col++) begin
            // Which buffered word feeds this column
            word = col / SPAN;
            src  = b2r_pkg::src_elem_index(int'(chunk_idx), col, NUM_CORES_H,
                                           NUM_CORES_V, BLOCK_SIZE, CHUNK_SIZE);
            pos  = word * ELEMS + src;
            row_out[col*WIDTH +: WIDTH] = slice_data[pos*WIDTH +: WIDTH];
        end
    end

endmodule

/* ram_1w1r.sv */
/* One write port, one read port. The read is registered, so dout follows
   read_addr by one cycle. A write and a read of one address on the same edge return old data. */
`timescale 1ns/100ps

module ram_1w1r #(
    parameter int DATA_WIDTH = 256,
    parameter int DEPTH      = 4
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         we,
    input  logic [b2r_pkg::clog2_safe(DEPTH)-1:0] write_addr,
    input  logic [b2r_pkg::clog2_safe(DEPTH)-1:0] read_addr,
    input  logic [DATA_WIDTH-1:0]                        din,
    output logic [DATA_WIDTH-1:0]                        dout
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout <= '0;
        end else begin
            dout <= mem[read_addr];
        end
    end

    a_write_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> (write_addr < DEPTH)
    );

endmodule

/* b2r_pkg.sv */
/* Shared definitions for the block-to-row output stage.
   requant_elem works in 64-bit arithmetic, so WIDTH must stay at 32 or below. */
package b2r_pkg;

    typedef enum logic [1:0] {
        idle,
        fill,
        slice_load,
        emit
    } conv_state_e;

    // Address width with a floor of one bit
    function automatic int clog2_safe(input int value);
        if (value <= 1) begin
            return 1;
        end
        return $clog2(value);
    endfunction

    // Element position inside the source word for output column col of chunk
    function automatic int src_elem_index(input int chunk, input int col,
                                          input int num_cores_h, input int num_cores_v,
                                          input int block_size, input int chunk_size);
        int blocks_per_core;
        int nv;
        int b;
        int h;
        int e;
        blocks_per_core = chunk_size / block_size;
        nv = chunk / blocks_per_core;
        b  = chunk % blocks_per_core;
        h  = (col / block_size) % num_cores_h;
        e  = col % block_size;
        return h * chunk_size * num_cores_v + nv * chunk_size + b * block_size + e;
    endfunction

    // Round half up, arithmetic shift, then clamp to the signed output range
    function automatic longint requant_elem(input longint value, input int frac_width,
                                            input int out_width);
        longint rounded;
        longint shifted;
        longint max_v;
        longint min_v;
        max_v   = (longint'(1) <<< (out_width - 1)) - 1;
        min_v   = -(longint'(1) <<< (out_width - 1));
        rounded = (frac_width > 0) ? value + (longint'(1) <<< (frac_width - 1)) : value;
        shifted = rounded >>> frac_width;
        if (shifted > max_v) begin
            return max_v;
        end
        if (shifted < min_v) begin
            return min_v;
        end
        return shifted;
    endfunction

endpackage
